//--- dv/md_unit_vectors.txt
# test_name  op  operand_a  operand_b  expected_hi  expected_lo  (all values hex)
# HI and LO carry over between lines, so a test that leaves one unchanged expects the prior value
mthi_basic          MTHI   12345678 00000000 12345678 00000000
mtlo_basic          MTLO   9abcdef0 ffffffff 12345678 9abcdef0
multu_small         MULTU  00000007 00000006 00000000 0000002a
multu_max           MULTU  ffffffff ffffffff fffffffe 00000001
mult_neg_pos        MULT   fffffffd 00000005 ffffffff fffffff1
mult_neg_neg        MULT   fffffff9 fffffffb 00000000 00000023
mult_min_by_two     MULT   80000000 00000002 ffffffff 00000000
multu_shift         MULTU  12345678 00010000 00001234 56780000
divu_basic          DIVU   00000064 00000007 00000002 0000000e
divu_big            DIVU   ffffffff 00000010 0000000f 0fffffff
divu_large_divisor  DIVU   ffffffff 80000001 7ffffffe 00000001
div_neg_pos         DIV    ffffff9c 00000007 fffffffe fffffff2
div_pos_neg         DIV    00000064 fffffff9 00000002 fffffff2
div_neg_neg         DIV    ffffff9c fffffff9 fffffffe 0000000e
divu_by_zero        DIVU   00001234 00000000 fffffffe 0000000e
div_by_zero         DIV    80000000 00000000 fffffffe 0000000e
mthi_zero           MTHI   00000000 00000000 00000000 0000000e
divu_small_dividend DIVU   00000003 00000009 00000003 00000000
mtlo_after_div      MTLO   cafef00d 00000000 00000003 cafef00d
div_exact           DIV    fffffff0 00000004 00000000 fffffffc

//--- md_unit.f
+incdir+include
logic/md_pkg.sv
logic/md_step_if.sv
logic/md_control.sv
logic/md_step_counter.sv
logic/md_iter_core.sv
logic/hilo_regs.sv
logic/md_unit.sv
dv/md_unit_properties.sv
dv/md_unit_tb.sv

//--- Bender.yml
package:
  name: md_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/md_pkg.sv
      - logic/md_step_if.sv
      - logic/md_control.sv
      - logic/md_step_counter.sv
      - logic/md_iter_core.sv
      - logic/hilo_regs.sv
      - logic/md_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/md_unit_properties.sv
      - dv/md_unit_tb.sv

//--- dv/md_unit_tb.sv
`default_nettype none

`include "md_macros.svh"

module md_unit_tb import md_pkg::*; ();

    localparam int    RESET_CYCLES = 10;
    localparam int    OP_LATENCY   = `MD_STEPS + 2;    // Load, steps, write back
    localparam int    MAX_GAP      = 5;
    localparam int    MAX_HOLD     = 4;
    localparam int    TXN_CYCLES   = OP_LATENCY + MAX_GAP + MAX_HOLD + 8;
    localparam string VECTOR_FILE  = "dv/md_unit_vectors.txt";

    logic   aclk;
    logic   aresetn;
    logic   req;
    md_op_t op;
    word_t  operand_a;
    word_t  operand_b;
    logic   ack;
    word_t  hi;
    word_t  lo;

    string  vec_name[$];
    md_op_t vec_op[$];
    word_t  vec_a[$];
    word_t  vec_b[$];
    word_t  vec_hi[$];
    word_t  vec_lo[$];
    int     cycle_count = 0;
    int     cycle_limit = 0;

    md_unit DUT (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .req       (req),
        .op        (op),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .ack       (ack),
        .hi        (hi),
        .lo        (lo)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    always @(posedge aclk) cycle_count <= cycle_count + 1;

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_word(input string test, input string field, input word_t exp,
                              input word_t act);
        if (act !== exp) begin
            $display("Fail %s %s: expected %h, actual %h", test, field, exp, act);
            abort_run();
        end
    endtask

    task automatic check_latency(input string test, input int exp, input int act);
        if (act != exp) begin
            $display("%s: ack came %0d cycles after req was taken, expected %0d",
                     test, act, exp);
            abort_run();
        end
    endtask

    function automatic bit decode_op_name(input string s, output md_op_t o);
        o = OP_MULT;
        case (s)
            "MULT":  o = OP_MULT;
            "MULTU": o = OP_MULTU;
            "DIV":   o = OP_DIV;
            "DIVU":  o = OP_DIVU;
            "MTHI":  o = OP_MTHI;
            "MTLO":  o = OP_MTLO;
            default: return 1'b0;
        endcase
        return 1'b1;
    endfunction

    task automatic load_vectors();
        int     fd;
        int     n;
        string  line;
        string  name;
        string  op_name;
        md_op_t op_val;
        word_t  a;
        word_t  b;
        word_t  exp_hi;
        word_t  exp_lo;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", VECTOR_FILE);
            abort_run();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line.getc(0) == "#")
                continue;
            n = $sscanf(line, "%s %s %h %h %h %h", name, op_name, a, b, exp_hi, exp_lo);
            if (n <= 0)
                continue;   // Blank line
            if (n != 6) begin
                $display("Malformed line in the vector file: %s", line);
                abort_run();
            end
            if (!decode_op_name(op_name, op_val)) begin
                $display("Unknown operation %s in test %s", op_name, name);
                abort_run();
            end
            vec_name.push_back(name);
            vec_op.push_back(op_val);
            vec_a.push_back(a);
            vec_b.push_back(b);
            vec_hi.push_back(exp_hi);
            vec_lo.push_back(exp_lo);
        end
        $fclose(fd);
        if (vec_name.size() == 0) begin
            $display("The vector file holds no tests");
            abort_run();
        end
    endtask

    task automatic run_vector(input int idx);
        int latency;
        int hold;
        int gap;
        hold = 1 + ($urandom % MAX_HOLD);
        gap  = $urandom % (MAX_GAP + 1);
        @(posedge aclk);
        req       <= 1'b1;
        op        <= vec_op[idx];
        operand_a <= vec_a[idx];
        operand_b <= vec_b[idx];
        @(posedge aclk);    // DUT takes req here
        latency = 0;
        @(negedge aclk);
        while (!ack) begin
            @(posedge aclk);
            latency++;
            @(negedge aclk);
        end
        check_latency(vec_name[idx],
                      (vec_op[idx] inside {OP_MTHI, OP_MTLO}) ? 1 : OP_LATENCY, latency);
        check_word(vec_name[idx], "HI", vec_hi[idx], hi);
        check_word(vec_name[idx], "LO", vec_lo[idx], lo);
        repeat (hold) begin
            @(negedge aclk);
            if (ack !== 1'b1) begin
                $display("%s: ack dropped while req was still high", vec_name[idx]);
                abort_run();
            end
            check_word(vec_name[idx], "HI held", vec_hi[idx], hi);
            check_word(vec_name[idx], "LO held", vec_lo[idx], lo);
        end
        @(posedge aclk);
        req <= 1'b0;
        @(posedge aclk);
        @(negedge aclk);
        if (ack !== 1'b0) begin
            $display("%s: ack still high after req was taken low", vec_name[idx]);
            abort_run();
        end
        repeat (gap) @(posedge aclk);
    endtask

    initial begin
        wait (cycle_limit > 0);
        wait (cycle_count >= cycle_limit);
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        abort_run();
    end

    // Stop at the first handshake assertion failure
    initial begin
        wait (DUT.u_properties.fail_count > 0);
        $display("A handshake assertion failed");
        abort_run();
    end

    initial begin
        void'($urandom(37276));
        aresetn   = 1'b0;
        req       = 1'b0;
        op        = OP_MULT;
        operand_a = '0;
        operand_b = '0;
        load_vectors();
        cycle_limit = RESET_CYCLES + vec_name.size() * TXN_CYCLES;
        repeat (RESET_CYCLES) @(posedge aclk);
        aresetn <= 1'b1;
        @(negedge aclk);
        check_word("reset", "HI", '0, hi);
        check_word("reset", "LO", '0, lo);
        foreach (vec_name[i]) run_vector(i);
        @(posedge aclk);
        if (DUT.u_properties.fail_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("%0d handshake assertion failures", DUT.u_properties.fail_count);
            abort_run();
        end
    end

endmodule

`default_nettype wire

//--- dv/md_unit_properties.sv
`default_nettype none

module md_unit_properties (
    input wire logic aclk,
    input wire logic aresetn,
    input wire logic req,
    input wire logic ack
);

    int fail_count = 0;     // Read by the testbench at the end

    // ack only answers a raised request
    ack_needs_req: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(ack) |-> $past(req))
        else begin
            $error("ack rose while req was low");
            fail_count++;
        end

    ack_holds: assert property (@(posedge aclk) disable iff (!aresetn)
        ack && req |=> ack)
        else begin
            $error("ack fell while req was still high");
            fail_count++;
        end

    ack_releases: assert property (@(posedge aclk) disable iff (!aresetn)
        ack && !req |=> !ack)
        else begin
            $error("ack stayed high after req was sampled low");
            fail_count++;
        end

endmodule

bind md_unit md_unit_properties u_properties (
    .aclk    (aclk),
    .aresetn (aresetn),
    .req     (req),
    .ack     (ack)
);

`default_nettype wire

//--- logic/md_unit.sv
`default_nettype none

// Multiply/divide unit with HI/LO behind a req/ack handshake
module md_unit import md_pkg::*; (
    input  wire logic   aclk,
    input  wire logic   aresetn,
    input  wire logic   req,
    input  wire md_op_t op,
    input  wire word_t  operand_a,
    input  wire word_t  operand_b,
    output logic        ack,
    output word_t       hi,
    output word_t       lo
);

    md_step_if steps ();

    word_t      result_hi;
    word_t      result_lo;
    logic       div_by_zero;
    logic [1:0] hilo_wen;

    md_control u_control (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .req         (req),
        .op          (op),
        .div_by_zero (div_by_zero),
        .steps       (steps.ctrl),
        .hilo_wen    (hilo_wen),
        .ack         (ack)
    );

    md_step_counter u_step_counter (
        .aclk    (aclk),
        .aresetn (aresetn),
        .steps   (steps.dp)
    );

    md_iter_core u_iter_core (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .steps       (steps.dp),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .result_hi   (result_hi),
        .result_lo   (result_lo),
        .div_by_zero (div_by_zero)
    );

    hilo_regs u_hilo_regs (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .hilo_wen  (hilo_wen),
        .op        (op),        // Held stable by the master until ack
        .operand_a (operand_a),
        .result_hi (result_hi),
        .result_lo (result_lo),
        .hi        (hi),
        .lo        (lo)
    );

endmodule

`default_nettype wire

//--- logic/hilo_regs.sv
`default_nettype none

module hilo_regs import md_pkg::*; (
    input  wire logic       aclk,
    input  wire logic       aresetn,
    input  wire logic [1:0] hilo_wen,
    input  wire md_op_t     op,
    input  wire word_t      operand_a,
    input  wire word_t      result_hi,
    input  wire word_t      result_lo,
    output word_t           hi,
    output word_t           lo
);

    logic  is_move;
    word_t hi_next;
    word_t lo_next;

    assign is_move = (op == OP_MTHI) || (op == OP_MTLO);
    assign hi_next = is_move ? operand_a : result_hi;
    assign lo_next = is_move ? operand_a : result_lo;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            hi <= '0;
            lo <= '0;
        end else begin
            if (hilo_wen[1]) hi <= hi_next;
            if (hilo_wen[0]) lo <= lo_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/md_iter_core.sv
`default_nettype none

`include "md_macros.svh"

module md_iter_core import md_pkg::*; (
    input  wire logic   aclk,
    input  wire logic   aresetn,
    md_step_if.dp       steps,
    input  wire word_t  operand_a,
    input  wire word_t  operand_b,
    output word_t       result_hi,
    output word_t       result_lo,
    output logic        div_by_zero
);

    localparam int W = `MD_WIDTH;

    word_t  a_mag;
    word_t  b_mag;
    word_t  b_q;        // Multiplicand or divisor
    dword_t acc;        // {upper, lower} working pair
    logic   sign_a;
    logic   sign_b;
    logic   neg_q;
    logic   rem_neg_q;
    logic   b_zero_q;

    logic [W:0] add_sum;
    logic [W:0] sub_diff;
    dword_t     prod;
    word_t      acc_hi;
    word_t      acc_lo;

    assign sign_a = steps.is_signed && operand_a[W-1];
    assign sign_b = steps.is_signed && operand_b[W-1];
    assign a_mag  = sign_a ? -operand_a : operand_a;
    assign b_mag  = sign_b ? -operand_b : operand_b;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            neg_q     <= 1'b0;
            rem_neg_q <= 1'b0;
            b_zero_q  <= 1'b0;
        end else if (steps.load) begin
            neg_q     <= sign_a ^ sign_b;
            rem_neg_q <= sign_a;    // Remainder follows dividend
            b_zero_q  <= (operand_b == '0);
        end
    end

    // Shift-add partial sum with carry out
    assign add_sum  = {1'b0, acc[2*W-1:W]} + (acc[0] ? {1'b0, b_q} : '0);
    // Restoring trial subtract on the shifted remainder
    assign sub_diff = acc[2*W-1:W-1] - {1'b0, b_q};

    always_ff @(posedge aclk) begin
        if (steps.load) begin
            acc <= {{W{1'b0}}, a_mag};
            b_q <= b_mag;
        end else if (steps.step) begin
            if (!steps.is_div)
                acc <= {add_sum, acc[W-1:1]};
            else if (!sub_diff[W])
                acc <= {sub_diff[W-1:0], acc[W-2:0], 1'b1};
            else
                acc <= {acc[2*W-2:0], 1'b0};
        end
    end

    assign acc_hi = acc[2*W-1:W];
    assign acc_lo = acc[W-1:0];
    assign prod   = neg_q ? -acc : acc;

    // Divide: remainder in HI, quotient in LO
    assign result_hi = steps.is_div ? (rem_neg_q ? -acc_hi : acc_hi) : prod[2*W-1:W];
    assign result_lo = steps.is_div ? (neg_q ? -acc_lo : acc_lo) : prod[W-1:0];

    assign div_by_zero = steps.is_div && b_zero_q;

endmodule

`default_nettype wire

//--- logic/md_step_counter.sv
`default_nettype none

`include "md_macros.svh"

module md_step_counter import md_pkg::*; (
    input  wire logic   aclk,
    input  wire logic   aresetn,
    md_step_if.dp       steps
);

    step_cnt_t count;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            count <= '0;
        end else if (steps.load) begin
            count <= '0;
        end else if (steps.step) begin
            count <= count + 1'b1;  // Wraps after the last step
        end
    end

    assign steps.last = steps.step && (count == step_cnt_t'(`MD_STEPS - 1));

endmodule

`default_nettype wire

//--- logic/md_control.sv
`default_nettype none

module md_control import md_pkg::*; (
    input  wire logic   aclk,
    input  wire logic   aresetn,
    input  wire logic   req,
    input  wire md_op_t op,
    input  wire logic   div_by_zero,
    md_step_if.ctrl     steps,
    output logic [1:0]  hilo_wen,
    output logic        ack
);

    typedef enum logic [1:0] {S_IDLE, S_ITER, S_WB, S_DONE} state_t;

    state_t state;
    md_op_t op_q;
    logic   load_q;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state  <= S_IDLE;
            op_q   <= OP_MULT;
            load_q <= 1'b0;
        end else begin
            load_q <= 1'b0;
            case (state)
                S_IDLE: if (req) begin
                    op_q <= op;
                    if (op == OP_MTHI || op == OP_MTLO) begin
                        state <= S_WB;      // Moves skip the datapath
                    end else begin
                        state  <= S_ITER;
                        load_q <= 1'b1;
                    end
                end
                S_ITER: if (steps.last) state <= S_WB;
                S_WB:   state <= S_DONE;
                S_DONE: if (!req) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    assign steps.load      = load_q;
    assign steps.step      = (state == S_ITER) && !load_q;
    assign steps.is_div    = (op_q == OP_DIV) || (op_q == OP_DIVU);
    assign steps.is_signed = (op_q == OP_MULT) || (op_q == OP_DIV);

    // HI is bit 1, LO is bit 0
    always_comb begin
        hilo_wen = 2'b00;
        if (state == S_WB) begin
            case (op_q)
                OP_MTHI: hilo_wen = 2'b10;
                OP_MTLO: hilo_wen = 2'b01;
                default: hilo_wen = div_by_zero ? 2'b00 : 2'b11;
            endcase
        end
    end

    assign ack = (state == S_DONE);

endmodule

`default_nettype wire

//--- logic/md_step_if.sv
`default_nettype none

// Iteration controls shared by counter and core
interface md_step_if;

    logic load;         // Capture operands, clear count
    logic step;         // One iteration
    logic is_div;
    logic is_signed;
    logic last;         // Final iteration

    modport ctrl (
        output load, step, is_div, is_signed,
        input  last
    );

    modport dp (
        input  load, step, is_div, is_signed,
        output last
    );

endinterface

`default_nettype wire

//--- logic/md_pkg.sv
`default_nettype none

`include "md_macros.svh"

package md_pkg;

    typedef logic [`MD_WIDTH-1:0]   word_t;
    typedef logic [2*`MD_WIDTH-1:0] dword_t;

    // Iteration index, wraps at MD_STEPS
    typedef logic [$clog2(`MD_STEPS)-1:0] step_cnt_t;

    typedef enum logic [2:0] {
        OP_MULT  = 3'd0,
        OP_MULTU = 3'd1,
        OP_DIV   = 3'd2,
        OP_DIVU  = 3'd3,
        OP_MTHI  = 3'd4,
        OP_MTLO  = 3'd5
    } md_op_t;

endpackage

`default_nettype wire

//--- include/md_macros.svh
`ifndef MD_MACROS_SVH
`define MD_MACROS_SVH

// Operand width of the multiply/divide unit
`define MD_WIDTH 32

// One iteration per operand bit
`define MD_STEPS 32

`endif
